//--- verilog/ll_cfg.svh
`ifndef LL_CFG_SVH
`define LL_CFG_SVH

// AXI4-Lite widths
`define LL_ADDR_W       32
`define LL_DATA_W       32
`define LL_STRB_W       4
`define LL_RESP_W       2
`define LL_W_BEAT_W     (`LL_STRB_W + `LL_DATA_W)
`define LL_R_BEAT_W     (`LL_RESP_W + `LL_DATA_W)
`define LL_PHY_W        160

// Receive depths, transmit credits match the far end's depths
`define LL_AR_DEPTH     8
`define LL_AW_DEPTH     8
`define LL_W_DEPTH      16
`define LL_R_CREDITS    8
`define LL_B_CREDITS    8

// Field offsets in rx_phy0
`define LL_RX_AR_PUSH   0
`define LL_RX_AR_ADDR   1
`define LL_RX_AW_PUSH   33
`define LL_RX_AW_ADDR   34
`define LL_RX_W_PUSH    66
`define LL_RX_W_BEAT    67
`define LL_RX_R_CRED    103
`define LL_RX_B_CRED    104

// Field offsets in tx_phy0
`define LL_TX_R_PUSH    0
`define LL_TX_R_BEAT    1
`define LL_TX_B_PUSH    35
`define LL_TX_B_RESP    36
`define LL_TX_AR_CRED   38
`define LL_TX_AW_CRED   39
`define LL_TX_W_CRED    40

`endif

//--- verilog/ll_pkg.sv
`include "ll_cfg.svh"

package ll_pkg;

  // AXI response codes
  typedef enum logic [`LL_RESP_W-1:0] {
    OKAY   = 2'b00,
    EXOKAY = 2'b01,
    SLVERR = 2'b10,
    DECERR = 2'b11
  } axi_resp_e;

  // Write beat as carried on the link, strobe on top
  typedef struct packed {
    logic [`LL_STRB_W-1:0] strb;
    logic [`LL_DATA_W-1:0] data;
  } w_beat_t;

  // Read beat as carried on the link, response on top
  typedef struct packed {
    axi_resp_e             resp;
    logic [`LL_DATA_W-1:0] data;
  } r_beat_t;

endpackage

//--- verilog/ll_chan_if.sv
// One link channel between the PHY codec and a channel endpoint
interface ll_chan_if #(
  parameter int WIDTH = 32
);

  logic             push;
  logic [WIDTH-1:0] data;
  logic             credit;
  logic             online;

  // Receive side, beats come in from the PHY, credits go back out
  modport rx_codec (output push, output data, output online, input credit);
  modport rx_end (input push, input data, input online, output credit);

  // Transmit side, beats go out to the PHY, credits come back in
  modport tx_end (output push, output data, input credit, input online);
  modport tx_codec (input push, input data, output credit, output online);

endinterface

//--- verilog/phy_word_codec.sv
`include "ll_cfg.svh"

module phy_word_codec (
  input  logic                 clk_wr,
  input  logic                 reset,
  input  logic                 tx_online,
  input  logic                 rx_online,
  input  logic [`LL_PHY_W-1:0] rx_phy0,
  output logic [`LL_PHY_W-1:0] tx_phy0,
  ll_chan_if.rx_codec          ar,
  ll_chan_if.rx_codec          aw,
  ll_chan_if.rx_codec          w,
  ll_chan_if.tx_codec          r,
  ll_chan_if.tx_codec          b
);

  logic                 link_up;
  logic [`LL_PHY_W-1:0] rx_word;
  logic [`LL_PHY_W-1:0] tx_word;

  ////////////////////////////////////////////////////////////////////////////
  // Receive direction

  always_ff @(posedge clk_wr) begin
    if (reset) begin
      link_up <= 1'b0;
      rx_word <= '0;
    end else begin
      link_up <= tx_online & rx_online;
      rx_word <= rx_phy0;
    end
  end

  // Pushes only count while the link is up
  assign ar.online = link_up;
  assign ar.push   = link_up & rx_word[`LL_RX_AR_PUSH];
  assign ar.data   = rx_word[`LL_RX_AR_ADDR +: `LL_ADDR_W];

  assign aw.online = link_up;
  assign aw.push   = link_up & rx_word[`LL_RX_AW_PUSH];
  assign aw.data   = rx_word[`LL_RX_AW_ADDR +: `LL_ADDR_W];

  assign w.online  = link_up;
  assign w.push    = link_up & rx_word[`LL_RX_W_PUSH];
  assign w.data    = rx_word[`LL_RX_W_BEAT +: `LL_W_BEAT_W];

  // Credits returned by the far end for our responses
  assign r.online  = link_up;
  assign r.credit  = link_up & rx_word[`LL_RX_R_CRED];
  assign b.online  = link_up;
  assign b.credit  = link_up & rx_word[`LL_RX_B_CRED];

  ////////////////////////////////////////////////////////////////////////////
  // Transmit direction

  always_comb begin
    tx_word                                  = '0;
    tx_word[`LL_TX_R_PUSH]                   = r.push;
    tx_word[`LL_TX_R_BEAT +: `LL_R_BEAT_W]   = r.data;
    tx_word[`LL_TX_B_PUSH]                   = b.push;
    tx_word[`LL_TX_B_RESP +: `LL_RESP_W]     = b.data;
    tx_word[`LL_TX_AR_CRED]                  = ar.credit;
    tx_word[`LL_TX_AW_CRED]                  = aw.credit;
    tx_word[`LL_TX_W_CRED]                   = w.credit;
  end

  // Idle word while down
  always_ff @(posedge clk_wr) begin
    if (reset) begin
      tx_phy0 <= '0;
    end else if (!link_up) begin
      tx_phy0 <= '0;
    end else begin
      tx_phy0 <= tx_word;
    end
  end

endmodule

//--- verilog/link_rx_fifo.sv
module link_rx_fifo #(
  parameter int WIDTH = 32,
  parameter int DEPTH = 8
) (
  input  logic             clk_wr,
  input  logic             reset,
  ll_chan_if.rx_end        chan,
  output logic [WIDTH-1:0] user_data,
  output logic             user_valid,
  input  logic             user_ready
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic [WIDTH-1:0] mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             wr_en;
  logic             rd_en;

  // Pointer step with wrap, depth need not be a power of two
  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  // A push into a full FIFO is dropped
  assign wr_en = chan.push && (count != CNT_W'(DEPTH));
  assign rd_en = user_valid && user_ready;

  assign user_valid  = (count != '0);
  assign user_data   = mem[rd_ptr];
  // One credit back per beat taken by the user
  assign chan.credit = rd_en;

  always_ff @(posedge clk_wr) begin
    if (wr_en) begin
      mem[wr_ptr] <= chan.data;
    end
  end

  // Flush while the link is down
  always_ff @(posedge clk_wr) begin
    if (reset || !chan.online) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (rd_en) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      case ({wr_en, rd_en})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

//--- verilog/link_tx_credit.sv
module link_tx_credit #(
  parameter int WIDTH   = 34,
  parameter int CREDITS = 8
) (
  input  logic             clk_wr,
  input  logic             reset,
  input  logic [WIDTH-1:0] user_data,
  input  logic             user_valid,
  output logic             user_ready,
  ll_chan_if.tx_end        chan
);

  localparam int CNT_W = $clog2(CREDITS + 1);

  logic [CNT_W-1:0] credit_cnt;
  logic             send;

  // Accept a response only with a credit in hand
  assign user_ready = chan.online && (credit_cnt != '0);
  assign send       = user_valid && user_ready;

  // Straight onto the link in the handshake cycle
  assign chan.push  = send;
  assign chan.data  = user_data;

  ////////////////////////////////////////////////////////////////////////////
  // Credit counter

  always_ff @(posedge clk_wr) begin
    if (reset || !chan.online) begin
      credit_cnt <= CNT_W'(CREDITS);
    end else begin
      case ({send, chan.credit})
        2'b10:   credit_cnt <= credit_cnt - 1'b1;
        2'b01:   credit_cnt <= credit_cnt + 1'b1;
        // Use and return together cancel out
        default: credit_cnt <= credit_cnt;
      endcase
    end
  end

endmodule

//--- verilog/axi_lite_slave_link_top.sv
`include "ll_cfg.svh"

module axi_lite_slave_link_top (
  input  logic                  clk_wr,
  input  logic                  reset,

  // Link control
  input  logic                  tx_online,
  input  logic                  rx_online,

  // PHY words
  output logic [`LL_PHY_W-1:0]  tx_phy0,
  input  logic [`LL_PHY_W-1:0]  rx_phy0,

  // AR channel
  output logic [`LL_ADDR_W-1:0] user_araddr,
  output logic                  user_arvalid,
  input  logic                  user_arready,

  // AW channel
  output logic [`LL_ADDR_W-1:0] user_awaddr,
  output logic                  user_awvalid,
  input  logic                  user_awready,

  // W channel
  output logic [`LL_DATA_W-1:0] user_wdata,
  output logic [`LL_STRB_W-1:0] user_wstrb,
  output logic                  user_wvalid,
  input  logic                  user_wready,

  // R channel
  input  logic [`LL_DATA_W-1:0] user_rdata,
  input  logic [`LL_RESP_W-1:0] user_rresp,
  input  logic                  user_rvalid,
  output logic                  user_rready,

  // B channel
  input  logic [`LL_RESP_W-1:0] user_bresp,
  input  logic                  user_bvalid,
  output logic                  user_bready
);

  import ll_pkg::*;

  w_beat_t w_beat;
  r_beat_t r_beat;

  ll_chan_if #(.WIDTH(`LL_ADDR_W))       ar_if ();
  ll_chan_if #(.WIDTH(`LL_ADDR_W))       aw_if ();
  ll_chan_if #(.WIDTH($bits(w_beat_t)))  w_if ();
  ll_chan_if #(.WIDTH($bits(r_beat_t)))  r_if ();
  ll_chan_if #(.WIDTH(`LL_RESP_W))       b_if ();

  ////////////////////////////////////////////////////////////////////////////
  // PHY boundary

  phy_word_codec phy_word_codec_inst (
    .clk_wr    (clk_wr),
    .reset     (reset),
    .tx_online (tx_online),
    .rx_online (rx_online),
    .rx_phy0   (rx_phy0),
    .tx_phy0   (tx_phy0),
    .ar        (ar_if.rx_codec),
    .aw        (aw_if.rx_codec),
    .w         (w_if.rx_codec),
    .r         (r_if.tx_codec),
    .b         (b_if.tx_codec)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Receive channels

  link_rx_fifo #(.WIDTH(`LL_ADDR_W), .DEPTH(`LL_AR_DEPTH)) rx_fifo_ar (
    .clk_wr     (clk_wr),
    .reset      (reset),
    .chan       (ar_if.rx_end),
    .user_data  (user_araddr),
    .user_valid (user_arvalid),
    .user_ready (user_arready)
  );

  link_rx_fifo #(.WIDTH(`LL_ADDR_W), .DEPTH(`LL_AW_DEPTH)) rx_fifo_aw (
    .clk_wr     (clk_wr),
    .reset      (reset),
    .chan       (aw_if.rx_end),
    .user_data  (user_awaddr),
    .user_valid (user_awvalid),
    .user_ready (user_awready)
  );

  link_rx_fifo #(.WIDTH($bits(w_beat_t)), .DEPTH(`LL_W_DEPTH)) rx_fifo_w (
    .clk_wr     (clk_wr),
    .reset      (reset),
    .chan       (w_if.rx_end),
    .user_data  (w_beat),
    .user_valid (user_wvalid),
    .user_ready (user_wready)
  );

  assign user_wdata = w_beat.data;
  assign user_wstrb = w_beat.strb;

  ////////////////////////////////////////////////////////////////////////////
  // Transmit channels

  assign r_beat.resp = axi_resp_e'(user_rresp);
  assign r_beat.data = user_rdata;

  link_tx_credit #(.WIDTH($bits(r_beat_t)), .CREDITS(`LL_R_CREDITS)) tx_credit_r (
    .clk_wr     (clk_wr),
    .reset      (reset),
    .user_data  (r_beat),
    .user_valid (user_rvalid),
    .user_ready (user_rready),
    .chan       (r_if.tx_end)
  );

  link_tx_credit #(.WIDTH(`LL_RESP_W), .CREDITS(`LL_B_CREDITS)) tx_credit_b (
    .clk_wr     (clk_wr),
    .reset      (reset),
    .user_data  (user_bresp),
    .user_valid (user_bvalid),
    .user_ready (user_bready),
    .chan       (b_if.tx_end)
  );

endmodule

//--- bench/ll_asserts.sv
`include "ll_cfg.svh"

module ll_asserts (
  input logic                                  clk_wr,
  input logic                                  reset,
  input logic                                  ar_push,
  input logic [$clog2(`LL_AR_DEPTH + 1)-1:0]   ar_count,
  input logic                                  aw_push,
  input logic [$clog2(`LL_AW_DEPTH + 1)-1:0]   aw_count,
  input logic                                  w_push,
  input logic [$clog2(`LL_W_DEPTH + 1)-1:0]    w_count,
  input logic                                  r_push,
  input logic                                  r_credit,
  input logic                                  r_online,
  input logic                                  b_push,
  input logic                                  b_credit,
  input logic                                  b_online,
  input logic [`LL_ADDR_W-1:0]                 user_araddr,
  input logic                                  user_arvalid,
  input logic                                  user_arready
);

  timeunit 1ns;
  timeprecision 1ps;

  localparam int R_CNT_W = $clog2(`LL_R_CREDITS + 1);
  localparam int B_CNT_W = $clog2(`LL_B_CREDITS + 1);

  logic [R_CNT_W-1:0] r_avail;
  logic [B_CNT_W-1:0] b_avail;

  // Credits granted by the far end, counted from the link side
  always_ff @(posedge clk_wr) begin
    if (reset || !r_online) begin
      r_avail <= R_CNT_W'(`LL_R_CREDITS);
    end else begin
      r_avail <= r_avail + R_CNT_W'(r_credit) - R_CNT_W'(r_push);
    end
  end

  always_ff @(posedge clk_wr) begin
    if (reset || !b_online) begin
      b_avail <= B_CNT_W'(`LL_B_CREDITS);
    end else begin
      b_avail <= b_avail + B_CNT_W'(b_credit) - B_CNT_W'(b_push);
    end
  end

  // Far end must respect our receive depth
  ar_no_overflow: assert property (@(posedge clk_wr) disable iff (reset)
    ar_push |-> ar_count != `LL_AR_DEPTH) else $error("AR push into a full FIFO");
  aw_no_overflow: assert property (@(posedge clk_wr) disable iff (reset)
    aw_push |-> aw_count != `LL_AW_DEPTH) else $error("AW push into a full FIFO");
  w_no_overflow: assert property (@(posedge clk_wr) disable iff (reset)
    w_push |-> w_count != `LL_W_DEPTH) else $error("W push into a full FIFO");

  // Transmit only with a credit in hand
  r_has_credit: assert property (@(posedge clk_wr) disable iff (reset)
    r_push |-> r_avail != '0) else $error("R push without credit");
  b_has_credit: assert property (@(posedge clk_wr) disable iff (reset)
    b_push |-> b_avail != '0) else $error("B push without credit");

  ar_stable: assert property (@(posedge clk_wr) disable iff (reset)
    user_arvalid && !user_arready |=> user_arvalid && $stable(user_araddr))
    else $error("AR valid or address changed before ready");

endmodule

bind axi_lite_slave_link_top ll_asserts ll_asserts_inst (
  .clk_wr       (clk_wr),
  .reset        (reset),
  .ar_push      (ar_if.push),
  .ar_count     (rx_fifo_ar.count),
  .aw_push      (aw_if.push),
  .aw_count     (rx_fifo_aw.count),
  .w_push       (w_if.push),
  .w_count      (rx_fifo_w.count),
  .r_push       (r_if.push),
  .r_credit     (r_if.credit),
  .r_online     (r_if.online),
  .b_push       (b_if.push),
  .b_credit     (b_if.credit),
  .b_online     (b_if.online),
  .user_araddr  (user_araddr),
  .user_arvalid (user_arvalid),
  .user_arready (user_arready)
);

//--- bench/tb_axi_lite_slave_link.sv
`include "ll_cfg.svh"

module tb_axi_lite_slave_link;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int MAX_ENTRIES = 32;
  localparam int KIND_READ   = 1;
  localparam int KIND_WRITE  = 2;

  logic                  clk_wr;
  logic                  reset;
  logic                  tx_online;
  logic                  rx_online;
  logic [`LL_PHY_W-1:0]  tx_phy0;
  logic [`LL_PHY_W-1:0]  rx_phy0;
  logic [`LL_ADDR_W-1:0] user_araddr;
  logic                  user_arvalid;
  logic                  user_arready;
  logic [`LL_ADDR_W-1:0] user_awaddr;
  logic                  user_awvalid;
  logic                  user_awready;
  logic [`LL_DATA_W-1:0] user_wdata;
  logic [`LL_STRB_W-1:0] user_wstrb;
  logic                  user_wvalid;
  logic                  user_wready;
  logic [`LL_DATA_W-1:0] user_rdata;
  logic [`LL_RESP_W-1:0] user_rresp;
  logic                  user_rvalid;
  logic                  user_rready;
  logic [`LL_RESP_W-1:0] user_bresp;
  logic                  user_bvalid;
  logic                  user_bready;

  // Five words per entry: kind, address, data, strobe, response
  logic [31:0] test_mem [MAX_ENTRIES*5];
  int          n_entries = 0;
  int          n_reads   = 0;
  logic [31:0] lcg_state = 32'd63;
  int          ar_hs     = 0;
  int          aw_hs     = 0;
  int          w_hs      = 0;
  int          ar_cred   = 0;
  int          aw_cred   = 0;
  int          w_cred    = 0;

  axi_lite_slave_link_top axi_lite_slave_link_top_inst (.*);

  initial begin
    clk_wr = 1'b0;
    forever #5 clk_wr = ~clk_wr;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Helpers

  function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  task automatic tick();
    @(posedge clk_wr);
    #1;
  endtask

  task automatic check_value(input string name, input logic [`LL_PHY_W-1:0] got,
                             input logic [`LL_PHY_W-1:0] exp);
    if (got !== exp) begin
      $display("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
      $display("*** TEST FAILED ***");
      $fatal(1, "check on %s failed", name);
    end
  endtask

  // One PHY word held for a single cycle
  task automatic send_rx_word(input logic [`LL_PHY_W-1:0] word);
    rx_phy0 = word;
    tick();
    rx_phy0 = '0;
  endtask

  task automatic take_read(output logic [31:0] addr);
    logic        done;
    logic [31:0] rnd;
    done = 1'b0;
    while (!done) begin
      rnd          = next_random();
      user_arready = rnd[9];
      if (user_arvalid && user_arready) begin
        done = 1'b1;
        addr = user_araddr;
      end
      tick();
    end
    user_arready = 1'b0;
  endtask

  // AW and W are taken independently, each with its own random ready
  task automatic take_write(output logic [31:0] addr, output logic [31:0] data,
                            output logic [3:0] strb);
    logic        aw_done;
    logic        w_done;
    logic [31:0] rnd;
    aw_done = 1'b0;
    w_done  = 1'b0;
    while (!(aw_done && w_done)) begin
      rnd          = next_random();
      user_awready = !aw_done && rnd[8];
      user_wready  = !w_done && rnd[12];
      if (user_awvalid && user_awready) begin
        aw_done = 1'b1;
        addr    = user_awaddr;
      end
      if (user_wvalid && user_wready) begin
        w_done = 1'b1;
        data   = user_wdata;
        strb   = user_wstrb;
      end
      tick();
    end
    user_awready = 1'b0;
    user_wready  = 1'b0;
  endtask

  task automatic send_read_resp(input logic [31:0] data, input logic [1:0] resp);
    logic        done;
    logic [31:0] rnd;
    done       = 1'b0;
    user_rdata = data;
    user_rresp = resp;
    while (!done) begin
      rnd = next_random();
      if (!user_rvalid) begin
        user_rvalid = rnd[10];
      end
      done = user_rvalid && user_rready;
      tick();
    end
    user_rvalid = 1'b0;
    check_value("tx_phy0 r push", tx_phy0[`LL_TX_R_PUSH], 1'b1);
    check_value("tx_phy0 r beat", tx_phy0[`LL_TX_R_BEAT +: `LL_R_BEAT_W], {resp, data});
  endtask

  task automatic send_write_resp(input logic [1:0] resp);
    logic        done;
    logic [31:0] rnd;
    done       = 1'b0;
    user_bresp = resp;
    while (!done) begin
      rnd = next_random();
      if (!user_bvalid) begin
        user_bvalid = rnd[11];
      end
      done = user_bvalid && user_bready;
      tick();
    end
    user_bvalid = 1'b0;
    check_value("tx_phy0 b push", tx_phy0[`LL_TX_B_PUSH], 1'b1);
    check_value("tx_phy0 b resp", tx_phy0[`LL_TX_B_RESP +: `LL_RESP_W], resp);
  endtask

  // Handshakes and credit bits, sampled mid-cycle
  always @(negedge clk_wr) begin
    if (user_arvalid && user_arready) ar_hs++;
    if (user_awvalid && user_awready) aw_hs++;
    if (user_wvalid && user_wready) w_hs++;
    if (tx_phy0[`LL_TX_AR_CRED]) ar_cred++;
    if (tx_phy0[`LL_TX_AW_CRED]) aw_cred++;
    if (tx_phy0[`LL_TX_W_CRED]) w_cred++;
  end

  initial begin
    int limit;
    @(negedge reset);
    limit = n_entries * 200;
    repeat (limit) @(posedge clk_wr);
    $display("Timeout: the run did not finish within %0d cycles", limit);
    $display("*** TEST FAILED ***");
    $fatal(1, "watchdog expired");
  end

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence

  initial begin
    logic [`LL_PHY_W-1:0] word;
    logic [31:0]          addr;
    logic [31:0]          data;
    logic [31:0]          rnd;
    logic [3:0]           strb;
    reset        = 1'b1;
    tx_online    = 1'b0;
    rx_online    = 1'b0;
    rx_phy0      = '0;
    user_arready = 1'b0;
    user_awready = 1'b0;
    user_wready  = 1'b0;
    user_rdata   = '0;
    user_rresp   = '0;
    user_rvalid  = 1'b0;
    user_bresp   = '0;
    user_bvalid  = 1'b0;
    for (int i = 0; i < MAX_ENTRIES * 5; i++) begin
      test_mem[i] = '0;
    end
    $readmemh("bench/testdata_link.hex", test_mem);
    while (n_entries < MAX_ENTRIES && (test_mem[5*n_entries] == KIND_READ ||
           test_mem[5*n_entries] == KIND_WRITE)) begin
      if (test_mem[5*n_entries] == KIND_READ) n_reads++;
      n_entries++;
    end
    if (n_entries == 0) begin
      $display("No transactions could be read from bench/testdata_link.hex");
      $display("*** TEST FAILED ***");
      $fatal(1, "empty test data");
    end
    repeat (2) @(posedge clk_wr);
    #1;
    reset = 1'b0;
    tick();

    // Quiet after reset, and pushes ignored while rx_online is low
    tx_online = 1'b1;
    word      = '0;
    word[`LL_RX_AR_PUSH] = 1'b1;
    word[`LL_RX_AW_PUSH] = 1'b1;
    word[`LL_RX_W_PUSH]  = 1'b1;
    send_rx_word(word);
    repeat (6) begin
      check_value("user_arvalid", user_arvalid, 1'b0);
      check_value("user_awvalid", user_awvalid, 1'b0);
      check_value("user_wvalid", user_wvalid, 1'b0);
      check_value("user_rready", user_rready, 1'b0);
      check_value("user_bready", user_bready, 1'b0);
      check_value("tx_phy0", tx_phy0, '0);
      tick();
    end
    rx_online = 1'b1;
    while (!user_rready) tick();
    check_value("user_bready", user_bready, 1'b1);

    // Remote manager sends every request up front, in file order
    for (int i = 0; i < n_entries; i++) begin
      word = '0;
      if (test_mem[5*i] == KIND_READ) begin
        word[`LL_RX_AR_PUSH]                 = 1'b1;
        word[`LL_RX_AR_ADDR +: `LL_ADDR_W]   = test_mem[5*i+1];
      end else begin
        word[`LL_RX_AW_PUSH]                 = 1'b1;
        word[`LL_RX_AW_ADDR +: `LL_ADDR_W]   = test_mem[5*i+1];
        word[`LL_RX_W_PUSH]                  = 1'b1;
        word[`LL_RX_W_BEAT +: `LL_W_BEAT_W]  = {test_mem[5*i+3][3:0], test_mem[5*i+2]};
      end
      send_rx_word(word);
    end

    // User side takes requests and answers them
    for (int i = 0; i < n_entries; i++) begin
      word = '0;
      if (test_mem[5*i] == KIND_READ) begin
        take_read(addr);
        check_value("user_araddr", addr, test_mem[5*i+1]);
        send_read_resp(test_mem[5*i+2], test_mem[5*i+4][1:0]);
        word[`LL_RX_R_CRED] = 1'b1;
      end else begin
        take_write(addr, data, strb);
        check_value("user_awaddr", addr, test_mem[5*i+1]);
        check_value("user_wdata", data, test_mem[5*i+2]);
        check_value("user_wstrb", strb, test_mem[5*i+3][3:0]);
        send_write_resp(test_mem[5*i+4][1:0]);
        word[`LL_RX_B_CRED] = 1'b1;
      end
      send_rx_word(word);
    end
    repeat (3) tick();
    check_value("ar handshakes", ar_hs, n_reads);
    check_value("aw handshakes", aw_hs, n_entries - n_reads);
    check_value("w handshakes", w_hs, n_entries - n_reads);
    check_value("ar credits", ar_cred, ar_hs);
    check_value("aw credits", aw_cred, aw_hs);
    check_value("w credits", w_cred, w_hs);

    // R credits run out when none come back
    for (int i = 0; i < `LL_R_CREDITS; i++) begin
      rnd = next_random();
      send_read_resp(rnd, rnd[1:0]);
    end
    rnd         = next_random();
    user_rdata  = rnd;
    user_rresp  = rnd[5:4];
    user_rvalid = 1'b1;
    repeat (10) begin
      check_value("user_rready", user_rready, 1'b0);
      tick();
    end
    word = '0;
    word[`LL_RX_R_CRED] = 1'b1;
    send_rx_word(word);
    while (!user_rready) tick();
    send_read_resp(rnd, rnd[5:4]);

    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

//--- bench/testdata_link.hex
// kind (1 read, 2 write)  address  data  strobe  response
// read data and response are what the user side answers with
2 00002000 a5a5a5a5 f 0
1 00001004 12345678 0 0
2 00002004 0badf00d 3 2
1 00001008 cafef00d 0 1
1 0000100c 89abcdef 0 2
2 00002008 deadbeef c 0
2 0000200c 00ff00ff 1 3
1 00001010 fedcba98 0 0
2 00002010 13579bdf 6 1
1 00001014 2468ace0 0 3
2 00002014 55aa55aa f 0
1 00001018 0f0f0f0f 0 0
2 00002018 f0e1d2c3 8 2
1 0000101c 76543210 0 1
2 0000201c 11223344 f 0
1 00001020 99887766 0 2

//--- flist.f
+incdir+verilog
verilog/ll_pkg.sv
verilog/ll_chan_if.sv
verilog/phy_word_codec.sv
verilog/link_rx_fifo.sv
verilog/link_tx_credit.sv
verilog/axi_lite_slave_link_top.sv
bench/ll_asserts.sv
bench/tb_axi_lite_slave_link.sv

//--- run.sh
#!/bin/sh
# Build and run the link testbench with Verilator
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f flist.f \
  --top-module tb_axi_lite_slave_link -o sim_tb
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q 'TEST FAILED' "$LOG"; then
  echo "Simulation reported a failure"
  exit 1
fi
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi
echo "Simulation finished without failures"
exit 0
